// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_eth_rx
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
rgmii_pkg.sv
crc32_eth.sv
frame_receiver.sv
rx_byte_fifo.sv
eth_rx_top.sv
tb_clock_gen.sv
tb_eth_rx.sv

// ==== crc32_eth.sv ====
`timescale 1ns/10ps

module crc32_eth (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               clear_i,
    input  logic                               en_i,
    input  logic [rgmii_pkg::GMII_WIDTH-1:0]   data_i,
    output logic [rgmii_pkg::FCS_BYTES*8-1:0]  crc_o
);

    import rgmii_pkg::*;

    logic [FCS_BYTES*8-1:0] crc_q;

    // one byte through the reflected LFSR, lsb first
    function automatic logic [FCS_BYTES*8-1:0] crc_step(
        input logic [FCS_BYTES*8-1:0] crc,
        input logic [GMII_WIDTH-1:0]  data
    );
        logic [FCS_BYTES*8-1:0] c;
        c = crc ^ {{(FCS_BYTES*8-GMII_WIDTH){1'b0}}, data};
        for (int i = 0; i < GMII_WIDTH; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY_REFLECTED;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            crc_q <= '1;
        end else if (en_i) begin
            crc_q <= crc_step(crc_q, data_i);
        end
    end

    // final xor, gives the FCS as sent on the wire
    assign crc_o = ~crc_q;

endmodule

// ==== eth_rx_top.sv ====
`timescale 1ns/10ps

module eth_rx_top (
    input  logic                                 clk_i,
    input  logic                                 rst_i,

    input  logic [rgmii_pkg::GMII_WIDTH-1:0]     rx_d_i,
    input  logic                                 rx_dv_i,

    input  logic                                 check_destination_i,
    input  logic [47:0]                          local_mac_i,
    input  logic [rgmii_pkg::PAYLOAD_WIDTH-1:0]  payload_bytes_i,

    input  logic                                 m_axis_tready_i,
    output logic [rgmii_pkg::GMII_WIDTH-1:0]     m_axis_tdata_o,
    output logic                                 m_axis_tvalid_o,
    output logic                                 m_axis_tlast_o,

    output logic                                 crc_err_o,
    output logic                                 frame_done_o
);

    import rgmii_pkg::*;

    // receiver to fifo write side
    logic                    wr_en;
    logic [GMII_WIDTH-1:0]   wr_data;
    logic                    wr_last;

    frame_receiver i_frame_receiver (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .rx_d_i             (rx_d_i),
        .rx_dv_i            (rx_dv_i),
        .check_destination_i(check_destination_i),
        .local_mac_i        (local_mac_i),
        .payload_bytes_i    (payload_bytes_i),
        .wr_en_o            (wr_en),
        .wr_data_o          (wr_data),
        .wr_last_o          (wr_last),
        .crc_err_o          (crc_err_o),
        .frame_done_o       (frame_done_o)
    );

    rx_byte_fifo i_rx_byte_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .wr_last_i (wr_last),
        .rd_ready_i(m_axis_tready_i),
        .rd_valid_o(m_axis_tvalid_o),
        .rd_data_o (m_axis_tdata_o),
        .rd_last_o (m_axis_tlast_o)
    );

endmodule

// ==== frame_receiver.sv ====
`timescale 1ns/10ps

module frame_receiver (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic [rgmii_pkg::GMII_WIDTH-1:0]     rx_d_i,
    input  logic                                 rx_dv_i,
    input  logic                                 check_destination_i,
    input  logic [47:0]                          local_mac_i,
    input  logic [rgmii_pkg::PAYLOAD_WIDTH-1:0]  payload_bytes_i,
    output logic                                 wr_en_o,
    output logic [rgmii_pkg::GMII_WIDTH-1:0]     wr_data_o,
    output logic                                 wr_last_o,
    output logic                                 crc_err_o,
    output logic                                 frame_done_o
);

    import rgmii_pkg::*;

    logic [2:0][GMII_WIDTH-1:0]     rxd_z;
    logic [2:0]                     rxdv_z;
    logic [GMII_WIDTH-1:0]          rx_byte;
    logic                           rx_valid;
    logic                           frame_start;

    rx_state_e                      state_q;
    rx_state_e                      state_d;
    logic [PAYLOAD_WIDTH-1:0]       cnt_q;

    logic [PREAMBLE_BYTES*8-1:0]    preamble_q;
    logic [GMII_WIDTH-1:0]          sfd_q;
    logic [HEADER_BYTES*8-1:0]      header_q;
    logic [FCS_BYTES*8-1:0]         fcs_rx_q;
    logic [FCS_BYTES*8-1:0]         fcs_calc_q;

    logic                           sync_ok;
    logic                           byte_state;
    logic                           data_last;
    logic                           pass_filter;
    logic [47:0]                    dst_mac;

    logic                           crc_clear;
    logic                           crc_en;
    logic [GMII_WIDTH-1:0]          crc_data;
    logic [FCS_BYTES*8-1:0]         crc_value;

    // oldest tap of the delay line is the byte being worked on
    assign rx_byte     = rxd_z[2];
    assign rx_valid    = rxdv_z[2];
    assign frame_start = rxdv_z[1] && !rxdv_z[2];

    assign sync_ok    = (preamble_q == {PREAMBLE_BYTES{PREAMBLE_VAL}}) && (sfd_q == SFD_VAL);
    assign byte_state = state_q inside {PREAMBLE, SFD, HEADER, DATA, FCS};
    assign data_last  = (state_q == DATA) && (cnt_q == payload_bytes_i - 1'b1);

    // first six header bytes, first byte on the wire is the msb
    assign dst_mac     = header_q[HEADER_BYTES*8-1 -: 48];
    assign pass_filter = !check_destination_i || (dst_mac == local_mac_i);

    assign crc_clear = (state_q == IDLE);
    assign crc_en    = (state_q == HEADER) || (state_q == DATA);
    assign crc_data  = rx_byte;

    crc32_eth i_crc (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .clear_i(crc_clear),
        .en_i   (crc_en),
        .data_i (crc_data),
        .crc_o  (crc_value)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (frame_start) begin
                    state_d = PREAMBLE;
                end
            end
            PREAMBLE: begin
                if (cnt_q == PAYLOAD_WIDTH'(PREAMBLE_BYTES - 1)) begin
                    state_d = SFD;
                end
            end
            SFD: begin
                if (cnt_q == PAYLOAD_WIDTH'(SFD_BYTES - 1)) begin
                    state_d = HEADER;
                end
            end
            HEADER: begin
                if (cnt_q == PAYLOAD_WIDTH'(HEADER_BYTES - 1)) begin
                    state_d = sync_ok ? DATA : IDLE;
                end
            end
            DATA: begin
                if (data_last) begin
                    state_d = FCS;
                end
            end
            FCS: begin
                if (cnt_q == PAYLOAD_WIDTH'(FCS_BYTES - 1)) begin
                    state_d = CRC_CHECK;
                end
            end
            CRC_CHECK: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
        // dv dropped inside the frame
        if (byte_state && !rx_valid) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxdv_z       <= '0;
            state_q      <= IDLE;
            cnt_q        <= '0;
            wr_en_o      <= 1'b0;
            wr_last_o    <= 1'b0;
            crc_err_o    <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            rxdv_z  <= {rxdv_z[1:0], rx_dv_i};
            state_q <= state_d;
            if ((state_d != state_q) || (state_q == IDLE)) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            wr_en_o      <= (state_q == DATA) && rx_valid && pass_filter;
            wr_last_o    <= data_last && rx_valid;
            frame_done_o <= (state_q == CRC_CHECK);
            if (state_q == CRC_CHECK) begin
                crc_err_o <= (fcs_calc_q != fcs_rx_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        rxd_z     <= {rxd_z[1:0], rx_d_i};
        wr_data_o <= rx_byte;
        if (state_q == PREAMBLE) begin
            preamble_q <= {preamble_q[PREAMBLE_BYTES*8-GMII_WIDTH-1:0], rx_byte};
        end
        if (state_q == SFD) begin
            sfd_q <= rx_byte;
        end
        if (state_q == HEADER) begin
            header_q <= {header_q[HEADER_BYTES*8-GMII_WIDTH-1:0], rx_byte};
        end
        // fcs arrives least significant byte first
        if (state_q == FCS) begin
            fcs_rx_q <= {rx_byte, fcs_rx_q[FCS_BYTES*8-1:GMII_WIDTH]};
        end
        // crc register has folded in the last payload byte by now
        if ((state_q == FCS) && (cnt_q == '0)) begin
            fcs_calc_q <= crc_value;
        end
    end

    a_wr_en_after_data: assert property (@(posedge clk_i) disable iff (rst_i)
        wr_en_o |-> $past((state_q == DATA) && sync_ok && (cnt_q < payload_bytes_i)))
        else $error("fifo write outside the payload window");

    a_frame_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        frame_done_o |=> !frame_done_o)
        else $error("frame_done_o held for more than one cycle");

endmodule

// ==== rgmii_pkg.sv ====
package rgmii_pkg;

    // receive symbol and length widths
    localparam int GMII_WIDTH    = 8;
    localparam int PAYLOAD_WIDTH = 11;

    // one maximum payload fits
    localparam int FIFO_DEPTH = 2048;

    // frame layout in bytes
    localparam int PREAMBLE_BYTES = 7;
    localparam int SFD_BYTES      = 1;
    localparam int HEADER_BYTES   = 14;
    localparam int FCS_BYTES      = 4;

    localparam logic [GMII_WIDTH-1:0] PREAMBLE_VAL = 8'h55;
    localparam logic [GMII_WIDTH-1:0] SFD_VAL      = 8'hd5;

    // IEEE 802.3 CRC-32, bit reversed
    localparam logic [31:0] CRC_POLY_REFLECTED = 32'hedb88320;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        HEADER,
        DATA,
        FCS,
        CRC_CHECK
    } rx_state_e;

endpackage

// ==== rx_byte_fifo.sv ====
`timescale 1ns/10ps

module rx_byte_fifo (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               wr_en_i,
    input  logic [rgmii_pkg::GMII_WIDTH-1:0]   wr_data_i,
    input  logic                               wr_last_i,
    input  logic                               rd_ready_i,
    output logic                               rd_valid_o,
    output logic [rgmii_pkg::GMII_WIDTH-1:0]   rd_data_o,
    output logic                               rd_last_o
);

    import rgmii_pkg::*;

    // byte plus last flag in the top bit
    logic [GMII_WIDTH:0]              mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]    wr_ptr_q;
    logic [$clog2(FIFO_DEPTH)-1:0]    rd_ptr_q;
    logic [$clog2(FIFO_DEPTH):0]      count_q;
    logic [GMII_WIDTH:0]              head;
    logic                             rd_fire;

    // fall-through read of the oldest entry
    assign head       = mem[rd_ptr_q];
    assign rd_valid_o = (count_q != '0);
    assign rd_data_o  = head[GMII_WIDTH-1:0];
    assign rd_last_o  = rd_valid_o && head[GMII_WIDTH];
    assign rd_fire    = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_ptr_q] <= {wr_last_i, wr_data_i};
        end
    end

    // power of two depth, pointers wrap by themselves
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en_i, rd_fire})
                2'b10: begin
                    count_q <= count_q + 1'b1;
                end
                2'b01: begin
                    count_q <= count_q - 1'b1;
                end
                default: begin
                    count_q <= count_q;
                end
            endcase
        end
    end

    // the receiver cannot stall, so the depth must cover its bursts
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        wr_en_i |-> (count_q < FIFO_DEPTH))
        else $error("write into a full fifo");

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

// ==== tb_eth_rx.sv ====
`timescale 1ns/10ps

module tb_eth_rx;

    import rgmii_pkg::*;

    typedef struct packed {
        logic [PAYLOAD_WIDTH-1:0] len;
        logic [47:0]              dst_mac;
        logic                     check_dst;
        logic                     bad_fcs;
        logic                     bad_sfd;
        logic                     exp_crc_err;
        logic                     exp_payload;
        logic                     exp_done;
    } frame_case_t;

    localparam logic [31:0] SEED          = 32'hc9f5340a;
    localparam logic [47:0] LOCAL_MAC     = 48'h02_00_5e_10_20_30;
    localparam logic [47:0] OTHER_MAC     = 48'h02_00_5e_10_20_31;
    localparam logic [47:0] SRC_MAC       = 48'h02_aa_bb_cc_dd_ee;
    localparam logic [15:0] ETHERTYPE     = 16'h88b5;
    localparam int          DONE_TIMEOUT  = 64;
    localparam int          DRAIN_TIMEOUT = 8000;
    localparam int          NUM_CASES     = 11;

    // len, dst, check_dst, bad_fcs, bad_sfd, exp_crc_err, exp_payload, exp_done
    localparam frame_case_t CASES [NUM_CASES] = '{
        '{11'd16,  LOCAL_MAC, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1},
        '{11'd23,  LOCAL_MAC, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1},
        '{11'd12,  OTHER_MAC, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{11'd12,  OTHER_MAC, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1},
        '{11'd20,  LOCAL_MAC, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
        '{11'd9,   LOCAL_MAC, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1},
        '{11'd1,   LOCAL_MAC, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1},
        '{11'd300, OTHER_MAC, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1},
        '{11'd64,  LOCAL_MAC, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1},
        '{11'd40,  OTHER_MAC, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1},
        '{11'd128, LOCAL_MAC, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1}
    };

    logic                       clk_i;
    logic                       rst_i;
    logic [GMII_WIDTH-1:0]      rx_d_i;
    logic                       rx_dv_i;
    logic                       check_destination_i;
    logic [47:0]                local_mac_i;
    logic [PAYLOAD_WIDTH-1:0]   payload_bytes_i;
    logic                       m_axis_tready_i;
    logic [GMII_WIDTH-1:0]      m_axis_tdata_o;
    logic                       m_axis_tvalid_o;
    logic                       m_axis_tlast_o;
    logic                       crc_err_o;
    logic                       frame_done_o;

    logic [7:0]   frame_q [$];
    // last flag in bit 8
    logic [8:0]   exp_q [$];
    logic [31:0]  payload_state;
    logic [31:0]  ready_state;
    int           rx_count;

    tb_clock_gen #(.PERIOD_NS(100.0)) i_clock_gen (
        .clk_o(clk_i)
    );

    eth_rx_top i_dut (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .rx_d_i             (rx_d_i),
        .rx_dv_i            (rx_dv_i),
        .check_destination_i(check_destination_i),
        .local_mac_i        (local_mac_i),
        .payload_bytes_i    (payload_bytes_i),
        .m_axis_tready_i    (m_axis_tready_i),
        .m_axis_tdata_o     (m_axis_tdata_o),
        .m_axis_tvalid_o    (m_axis_tvalid_o),
        .m_axis_tlast_o     (m_axis_tlast_o),
        .crc_err_o          (crc_err_o),
        .frame_done_o       (frame_done_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // bit serial form of the reflected crc, one input bit per step
    function automatic logic [31:0] crc_fold(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c = c >> 1;
            if (fb) begin
                c = c ^ CRC_POLY_REFLECTED;
            end
        end
        return c;
    endfunction

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL @ %0t: %s got %h expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic build_frame(input frame_case_t fc);
        logic [HEADER_BYTES*8-1:0] hdr;
        logic [31:0]               crc;
        logic [7:0]                b;
        frame_q.delete();
        hdr = {fc.dst_mac, SRC_MAC, ETHERTYPE};
        crc = 32'hffff_ffff;
        for (int i = 0; i < PREAMBLE_BYTES; i++) begin
            frame_q.push_back(PREAMBLE_VAL);
        end
        frame_q.push_back(fc.bad_sfd ? 8'hd4 : SFD_VAL);
        for (int i = 0; i < HEADER_BYTES; i++) begin
            b = hdr[HEADER_BYTES*8-1-8*i -: 8];
            frame_q.push_back(b);
            crc = crc_fold(crc, b);
        end
        for (int i = 0; i < int'(fc.len); i++) begin
            payload_state = xorshift32(payload_state);
            b = payload_state[7:0];
            frame_q.push_back(b);
            crc = crc_fold(crc, b);
            if (fc.exp_payload) begin
                exp_q.push_back({(i == int'(fc.len) - 1), b});
            end
        end
        crc = ~crc;
        if (fc.bad_fcs) begin
            crc = crc ^ 32'h0000_8000;
        end
        // fcs goes out low byte first
        for (int i = 0; i < FCS_BYTES; i++) begin
            frame_q.push_back(crc[8*i +: 8]);
        end
    endtask

    task automatic send_frame(input int idx, input frame_case_t fc);
        logic seen;
        int   wait_cycles;
        payload_bytes_i     = fc.len;
        check_destination_i = fc.check_dst;
        foreach (frame_q[n]) begin
            @(negedge clk_i);
            rx_dv_i = 1'b1;
            rx_d_i  = frame_q[n];
        end
        @(negedge clk_i);
        rx_dv_i = 1'b0;
        rx_d_i  = '0;
        seen = 1'b0;
        wait_cycles = 0;
        while (!seen && wait_cycles < DONE_TIMEOUT) begin
            @(negedge clk_i);
            wait_cycles++;
            if (frame_done_o) begin
                seen = 1'b1;
            end
        end
        if (fc.exp_done && !seen) begin
            $display("frame %0d: frame_done_o did not arrive within %0d cycles", idx, DONE_TIMEOUT);
            stop_with_failure();
        end else if (fc.exp_done) begin
            check_value($sformatf("frame %0d crc_err_o", idx), crc_err_o, fc.exp_crc_err);
        end else begin
            check_value($sformatf("frame %0d frame_done_o", idx), seen, 1'b0);
        end
        repeat (4) @(negedge clk_i);
    endtask

    // consumer with random back-pressure, outputs read at the falling edge
    initial begin : consumer
        logic       ready_bit;
        logic [8:0] exp_entry;
        m_axis_tready_i = 1'b0;
        ready_state = {SEED[15:0], SEED[31:16]};
        forever begin
            @(negedge clk_i);
            ready_state = xorshift32(ready_state);
            ready_bit = ready_state[0];
            if (ready_bit && m_axis_tvalid_o && exp_q.size() == 0) begin
                $display("output byte %h appeared at %0t with none expected",
                         m_axis_tdata_o, $time);
                stop_with_failure();
            end else if (ready_bit && m_axis_tvalid_o) begin
                exp_entry = exp_q.pop_front();
                check_value($sformatf("byte %0d tdata", rx_count), m_axis_tdata_o,
                            exp_entry[7:0]);
                check_value($sformatf("byte %0d tlast", rx_count), m_axis_tlast_o,
                            exp_entry[8]);
                rx_count++;
            end
            m_axis_tready_i = ready_bit;
        end
    end

    initial begin : main
        int wait_cycles;
        rx_count            = 0;
        payload_state       = SEED;
        rst_i               = 1'b1;
        rx_d_i              = '0;
        rx_dv_i             = 1'b0;
        check_destination_i = 1'b0;
        local_mac_i         = LOCAL_MAC;
        payload_bytes_i     = 11'd1;
        repeat (3) @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);
        check_value("tvalid after reset", m_axis_tvalid_o, 1'b0);
        check_value("crc_err_o after reset", crc_err_o, 1'b0);
        check_value("frame_done_o after reset", frame_done_o, 1'b0);

        for (int idx = 0; idx < NUM_CASES; idx++) begin
            build_frame(CASES[idx]);
            send_frame(idx, CASES[idx]);
        end

        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
            @(negedge clk_i);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d payload bytes were never delivered", exp_q.size());
            stop_with_failure();
        end
        repeat (8) @(negedge clk_i);
        check_value("tvalid after drain", m_axis_tvalid_o, 1'b0);

        $display("*** PASSED ***");
        $finish;
    end

endmodule
